/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := img_switch_tb
FILE_LIST := img_switch_top.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILE_LIST))) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)

/* img_switch_top.f */
+incdir+verilog
verilog/img_pkg.sv
verilog/img_pattern_gen.sv
verilog/img_selector_core.sv
verilog/img_frame_stats.sv
verilog/img_switch_top.sv
verif/img_switch_checker.sv
verif/img_switch_tb.sv

/* verif/img_switch_checker.sv */
// output checker for the video switch covering pixel rule, framing, switch timing and stats.
`timescale 1ns/100ps
`include "img_consts.svh"

module img_switch_checker
    import img_pkg::*;
(
    input  logic       m_img,
    input  logic       reset,
    input  logic       cke,
    input  sel_t       sel,
    input  img_beat_t  m_beat,
    input  frame_cnt_t frame_count,
    input  logic       torn,
    input  logic       test_end,
    input  logic       run_done,
    input  int         test_num,
    output int         match_frames,
    output int         error_count
);

    localparam int FRAME_BEATS = `IMG_ROWS * `IMG_COLS;

    logic       reset_prev;
    logic       cke_prev;
    img_beat_t  beat_prev;
    frame_cnt_t count_prev;
    frame_cnt_t exp_count;    // good frames seen so far.
    logic       in_frame;
    logic       have_last;
    logic       pending;      // waiting for the first frame of target.
    sel_t       target;
    sel_t       sel_prev;
    user_t      frame_src;
    user_t      last_src;
    logic [3:0] last_fnum;
    int         exp_row;
    int         exp_col;
    int         beat_cnt;
    int         switch_cnt;
    int         test_errors;
    int         total_frames;
    int         tests_done;

    initial begin
        error_count = 0;
        match_frames = 0;
        test_errors = 0;
        total_frames = 0;
        tests_done = 0;
        reset_prev = 1'b1;
        cke_prev = 1'b0;
    end

    // period of one source in enabled cycles.
    function automatic int frame_period(input int src);
        return FRAME_BEATS + `IMG_FRAME_GAP + 3 * src;
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic open_frame();
        logic [3:0] fnum;
        fnum = m_beat.data[11:8];
        if (in_frame) report_error("frame start inside an open frame");
        if (m_beat.user != user_t'(target) && !(pending && have_last && m_beat.user == last_src))
            report_error($sformatf("frame from source %0d, expected %0d", m_beat.user, target));
        if (have_last && m_beat.user == last_src && fnum != last_fnum + 4'd1)
            report_error($sformatf("frame number %0d follows %0d", fnum, last_fnum));
        if (pending && m_beat.user == user_t'(target)) begin
            if (switch_cnt > 2 * frame_period(int'(target)))
                report_error($sformatf("switch to %0d took %0d cycles", target, switch_cnt));
            pending = 1'b0;
        end
        in_frame = 1'b1;
        have_last = 1'b1;
        frame_src = m_beat.user;
        last_src = m_beat.user;
        last_fnum = fnum;
        exp_row = 0;
        exp_col = 0;
        beat_cnt = 0;
    endtask

    task automatic close_frame();
        in_frame = 1'b0;
        if (beat_cnt != FRAME_BEATS) begin
            report_error($sformatf("frame of %0d beats", beat_cnt));
        end else begin
            exp_count++;
            total_frames++;
            if (frame_src == user_t'(target)) match_frames++;
        end
    endtask

    task automatic check_beat();
        if (m_beat.row_first && m_beat.col_first) open_frame();
        if (!in_frame) begin
            report_error("valid beat outside a frame");
            return;
        end
        if (m_beat.rows != rows_t'(`IMG_ROWS) || m_beat.cols != cols_t'(`IMG_COLS))
            report_error("frame size fields wrong");
        if (!m_beat.de) report_error("de low on a valid beat");
        if (m_beat.user != frame_src) report_error("source changed inside a frame");
        if (m_beat.data[15:12] != 4'(m_beat.user))
            report_error($sformatf("pixel %h does not match user %0d", m_beat.data, m_beat.user));
        if (m_beat.data[7:4] != 4'(exp_row) || m_beat.data[3:0] != 4'(exp_col))
            report_error($sformatf("pixel %h at row %0d col %0d", m_beat.data, exp_row, exp_col));
        if (m_beat.row_first != (exp_row == 0) || m_beat.col_first != (exp_col == 0) ||
            m_beat.row_last != (exp_row == `IMG_ROWS - 1) ||
            m_beat.col_last != (exp_col == `IMG_COLS - 1))
            report_error("raster flags out of order");
        beat_cnt++;
        if (exp_col == `IMG_COLS - 1) begin
            exp_col = 0;
            exp_row++;
        end else begin
            exp_col++;
        end
        if (m_beat.row_last && m_beat.col_last) close_frame();
    endtask

    always @(posedge m_img) begin
        if (reset) begin
            in_frame = 1'b0;
            have_last = 1'b0;
            pending = 1'b0;
            target = sel;
            sel_prev = sel;
            exp_count = '0;
            switch_cnt = 0;
            beat_cnt = 0;
        end else begin
            if (sel != sel_prev) begin
                pending = 1'b1;
                switch_cnt = 0;
                target = sel;
                match_frames = 0;
            end
            sel_prev = sel;
            if (pending && cke) switch_cnt++;
            if (!reset_prev) begin
                if (!cke_prev) begin
                    // stalled pipeline holds its outputs.
                    if (m_beat !== beat_prev || frame_count !== count_prev)
                        report_error("output moved while cke was low");
                end else begin
                    if (torn) report_error("torn flag raised");
                    if (frame_count !== exp_count)
                        report_error($sformatf("frame_count %0d, expected %0d",
                                               frame_count, exp_count));
                    if (m_beat.valid) check_beat();
                end
            end
            if (test_end) begin
                $display("test %0d sel %0d: %0d frames, %0d errors",
                         test_num, target, match_frames, test_errors);
                tests_done++;
                test_errors = 0;
                match_frames = 0;
            end
            if (run_done)
                $display("tests %0d, frames %0d, errors %0d", tests_done, total_frames, error_count);
        end
        reset_prev = reset;
        cke_prev = cke;
        beat_prev = m_beat;
        count_prev = frame_count;
    end

endmodule

/* verif/img_switch_tb.sv */
// testbench for the video source switch with clock, reset, stimulus table and timeout.
`timescale 1ns/100ps
`include "img_consts.svh"

module img_switch_tb
    import img_pkg::*;
();

    localparam int FRAME_BEATS = `IMG_ROWS * `IMG_COLS;
    localparam int MAX_GAP = `IMG_FRAME_GAP + 3 * (`IMG_NUM_SRC - 1);
    localparam int NUM_TESTS = 6;

    // one row of the stimulus table.
    typedef struct packed {
        sel_t       sel;
        logic [7:0] frames;       // complete frames to collect.
        logic       rand_cke;
        logic       mid_frame;    // switch while a frame is on the output.
    } test_entry_t;

    logic       m_img;
    logic       reset;
    logic       cke;
    sel_t       sel;
    img_beat_t  m_beat;
    frame_cnt_t frame_count;
    logic       torn;

    logic test_end;
    logic run_done;
    int   test_num;
    int   match_frames;
    int   error_count;

    test_entry_t tests [NUM_TESTS];
    int seed = 22447;
    int cycles = 0;
    int cycle_limit;

    img_switch_top dut0 (
        .m_img       (m_img),
        .reset       (reset),
        .cke         (cke),
        .sel         (sel),
        .m_beat      (m_beat),
        .frame_count (frame_count),
        .torn        (torn)
    );

    img_switch_checker chk0 (
        .m_img        (m_img),
        .reset        (reset),
        .cke          (cke),
        .sel          (sel),
        .m_beat       (m_beat),
        .frame_count  (frame_count),
        .torn         (torn),
        .test_end     (test_end),
        .run_done     (run_done),
        .test_num     (test_num),
        .match_frames (match_frames),
        .error_count  (error_count)
    );

    initial begin
        m_img = 1'b0;
        forever #10 m_img = ~m_img;
    end

    // cycles the whole table may take.
    function automatic int run_limit();
        int total;
        total = 8 + 4;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += (int'(tests[i].frames) + 3) * (FRAME_BEATS + MAX_GAP + 7)
                     * (tests[i].rand_cke ? 2 : 1);
        end
        return total;
    endfunction

    task automatic next_cycle(input logic rand_cke);
        @(negedge m_img);
        if (rand_cke) cke = (($random(seed) & 3) != 0);    // low about one cycle in four.
        else cke = 1'b1;
    endtask

    task automatic wait_output_start();
        next_cycle(1'b0);
        while (!(m_beat.valid && m_beat.row_first && m_beat.col_first)) next_cycle(1'b0);
    endtask

    always @(posedge m_img) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        cke = 1'b1;
        sel = '0;
        test_end = 1'b0;
        run_done = 1'b0;
        test_num = 0;
        tests[0] = '{2'd0, 8'd3, 1'b0, 1'b0};
        tests[1] = '{2'd1, 8'd3, 1'b0, 1'b0};
        tests[2] = '{2'd2, 8'd3, 1'b0, 1'b0};
        tests[3] = '{2'd0, 8'd2, 1'b0, 1'b0};
        tests[4] = '{2'd1, 8'd4, 1'b1, 1'b0};
        tests[5] = '{2'd2, 8'd3, 1'b0, 1'b1};
        cycle_limit = run_limit();
        repeat (8) @(negedge m_img);
        reset = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_num = t;
            if (tests[t].mid_frame) begin
                wait_output_start();
                repeat (10) next_cycle(1'b0);
            end
            sel = tests[t].sel;
            next_cycle(tests[t].rand_cke);
            while (match_frames < int'(tests[t].frames)) next_cycle(tests[t].rand_cke);
            cke = 1'b1;
            test_end = 1'b1;
            @(negedge m_img);
            test_end = 1'b0;
        end
        run_done = 1'b1;
        @(negedge m_img);
        run_done = 1'b0;
        @(negedge m_img);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog/img_consts.svh */
// image switch constants for source count, frame geometry, gaps and widths.
`ifndef IMG_CONSTS_SVH
`define IMG_CONSTS_SVH

// number of pattern sources on the switch.
`define IMG_NUM_SRC 3

// frame geometry in pixels and lines.
`define IMG_COLS 8
`define IMG_ROWS 4

// one tap, one channel.
`define IMG_DATA_BITS 16

// idle beats after each frame; each source adds 3 per index.
`define IMG_FRAME_GAP 5

// width of the good frame counter.
`define IMG_FRAME_CNT_BITS 8

`endif

/* verilog/img_frame_stats.sv */
// output frame statistics counting complete frames and flagging torn ones.
`timescale 1ns/100ps
`include "img_consts.svh"

module img_frame_stats
    import img_pkg::*;
(
    input  logic       m_img,
    input  logic       reset,
    input  logic       cke,
    input  img_beat_t  beat,
    output frame_cnt_t frame_count,
    output logic       torn
);

    localparam int FRAME_BEATS = `IMG_ROWS * `IMG_COLS;
    localparam int CNT_BITS = $clog2(FRAME_BEATS + 1);

    logic                open;        // inside a frame.
    logic [CNT_BITS-1:0] beat_cnt;
    logic                frame_start;
    logic                frame_end;

    assign frame_start = beat.valid & beat.row_first & beat.col_first;
    assign frame_end = beat.valid & beat.row_last & beat.col_last;

    always_ff @(posedge m_img) begin
        if (reset) begin
            open <= 1'b0;
            beat_cnt <= '0;
            frame_count <= '0;
            torn <= 1'b0;
        end else if (cke) begin
            torn <= 1'b0;
            if (frame_start) begin
                open <= 1'b1;
                beat_cnt <= CNT_BITS'(1);
                if (open) torn <= 1'b1;    // nested start.
            end else if (beat.valid && open) begin
                beat_cnt <= beat_cnt + CNT_BITS'(1);
                if (frame_end) begin
                    open <= 1'b0;
                    if (beat_cnt == CNT_BITS'(FRAME_BEATS - 1)) begin
                        frame_count <= frame_count + frame_cnt_t'(1);
                    end else begin
                        torn <= 1'b1;
                    end
                end
            end else if (frame_end) begin
                torn <= 1'b1;    // end without a start.
            end
        end
    end

    // a violation is only seen on an enabled beat.
    assert property (@(posedge m_img) disable iff (reset)
        $rose(torn) |-> $past(cke));

endmodule

/* verilog/img_pattern_gen.sv */
// free-running raster source producing numbered frames with coded pixels.
`timescale 1ns/100ps
`include "img_consts.svh"

module img_pattern_gen
    import img_pkg::*;
#(
    parameter int SRC_ID = 0
) (
    input  logic      m_img,
    input  logic      reset,
    input  logic      cke,
    output img_beat_t m_beat
);

    localparam int START_DELAY = SRC_ID * 7;
    localparam int GAP_LEN = `IMG_FRAME_GAP + 3 * SRC_ID;

    typedef enum logic [1:0] {
        START_WAIT,
        ACTIVE,
        GAP
    } gen_state_t;

    gen_state_t state;
    logic [4:0] wait_cnt;
    rows_t      row;
    cols_t      col;
    logic [3:0] frame_num;    // wraps at 16.
    img_beat_t  beat_d;

    logic row_end;
    logic col_end;
    assign row_end = (row == rows_t'(`IMG_ROWS - 1));
    assign col_end = (col == cols_t'(`IMG_COLS - 1));

    // beat for the current counter position.
    always_comb begin
        beat_d = '0;
        beat_d.rows = rows_t'(`IMG_ROWS);
        beat_d.cols = cols_t'(`IMG_COLS);
        beat_d.user = user_t'(SRC_ID);
        beat_d.data = pix_data_t'({4'(SRC_ID), frame_num, 4'(row), 4'(col)});
        if (state == ACTIVE) begin
            beat_d.valid = 1'b1;
            beat_d.de = 1'b1;
            beat_d.row_first = (row == '0);
            beat_d.row_last = row_end;
            beat_d.col_first = (col == '0);
            beat_d.col_last = col_end;
        end
    end

    always_ff @(posedge m_img) begin
        if (reset) begin
            state <= (START_DELAY == 0) ? ACTIVE : START_WAIT;
            wait_cnt <= '0;
            row <= '0;
            col <= '0;
            frame_num <= '0;
            m_beat <= '0;
        end else if (cke) begin
            m_beat <= beat_d;
            case (state)
                START_WAIT: begin
                    wait_cnt <= wait_cnt + 5'd1;
                    if (wait_cnt == 5'(START_DELAY - 1)) begin
                        wait_cnt <= '0;
                        state <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (col_end) begin
                        col <= '0;
                        if (row_end) begin
                            row <= '0;
                            state <= GAP;    // last beat of the frame.
                        end else begin
                            row <= row + rows_t'(1);
                        end
                    end else begin
                        col <= col + cols_t'(1);
                    end
                end
                GAP: begin
                    wait_cnt <= wait_cnt + 5'd1;
                    if (wait_cnt == 5'(GAP_LEN - 1)) begin
                        wait_cnt <= '0;
                        frame_num <= frame_num + 4'd1;
                        state <= ACTIVE;
                    end
                end
                default: state <= START_WAIT;
            endcase
        end
    end

    // line end only on a real beat.
    assert property (@(posedge m_img) disable iff (reset)
        m_beat.col_last |-> m_beat.valid);

endmodule

/* verilog/img_pkg.sv */
// image switch types, the stream beat struct and the width typedefs.
`include "img_consts.svh"

package img_pkg;

    typedef logic [$clog2(`IMG_NUM_SRC)-1:0] sel_t;    // source index.
    typedef logic [2:0] rows_t;
    typedef logic [3:0] cols_t;
    typedef logic [`IMG_DATA_BITS-1:0] pix_data_t;
    typedef logic [1:0] user_t;                        // producing source.
    typedef logic [`IMG_FRAME_CNT_BITS-1:0] frame_cnt_t;

    // one beat of the pixel stream.
    typedef struct packed {
        rows_t     rows;
        cols_t     cols;
        logic      row_first;
        logic      row_last;
        logic      col_first;
        logic      col_last;
        logic      de;
        pix_data_t data;
        user_t     user;
        logic      valid;
    } img_beat_t;

endpackage

/* verilog/img_selector_core.sv */
// source selector that switches streams only at frame boundaries.
`timescale 1ns/100ps
`include "img_consts.svh"

module img_selector_core
    import img_pkg::*;
(
    input  logic      m_img,
    input  logic      reset,
    input  logic      cke,
    input  sel_t      sel,
    input  img_beat_t s_beat [`IMG_NUM_SRC],
    output img_beat_t m_beat
);

    // sel may come from a switch or another clock domain.
    sel_t sync_ff0;
    sel_t sync_ff1;

    always_ff @(posedge m_img) begin
        sync_ff0 <= sel;
        sync_ff1 <= sync_ff0;
    end

    sel_t next_sel;
    sel_t current_sel;
    logic busy;    // a frame of current_sel is on the output.

    // out of range requests fall back to source 0.
    assign next_sel = (sync_ff1 < sel_t'(`IMG_NUM_SRC)) ? sync_ff1 : sel_t'(0);

    img_beat_t next_beat;
    img_beat_t current_beat;
    img_beat_t idle_beat;

    assign next_beat = s_beat[next_sel];
    assign current_beat = s_beat[current_sel];

    logic next_frame_start;
    logic current_frame_end;
    assign next_frame_start = next_beat.valid & next_beat.row_first & next_beat.col_first;
    assign current_frame_end = m_beat.valid & m_beat.row_last & m_beat.col_last;

    // beats of a frame already in flight are dropped while idle.
    always_comb begin
        idle_beat = next_beat;
        idle_beat.valid = 1'b0;
        idle_beat.de = 1'b0;
        idle_beat.row_first = 1'b0;
        idle_beat.row_last = 1'b0;
        idle_beat.col_first = 1'b0;
        idle_beat.col_last = 1'b0;
    end

    always_ff @(posedge m_img) begin
        if (reset) begin
            busy <= 1'b0;
            current_sel <= next_sel;
            m_beat.rows <= '0;
            m_beat.cols <= '0;
            m_beat.row_first <= 1'b0;
            m_beat.row_last <= 1'b0;
            m_beat.col_first <= 1'b0;
            m_beat.col_last <= 1'b0;
            m_beat.de <= 1'b0;
            m_beat.valid <= 1'b0;
        end else if (cke) begin
            if (!busy || current_frame_end) begin
                busy <= next_frame_start;
                current_sel <= next_sel;
                m_beat <= next_frame_start ? next_beat : idle_beat;
            end else begin
                m_beat <= current_beat;    // hold the source mid frame.
            end
        end
    end

    // source only moves between frames.
    assert property (@(posedge m_img) disable iff (reset)
        (!$past(reset) && $changed(current_sel)) |-> $past(!busy || current_frame_end));

    assert property (@(posedge m_img) disable iff (reset)
        current_sel < sel_t'(`IMG_NUM_SRC));

endmodule

/* verilog/img_switch_top.sv */
// video source switch top with pattern sources, selector and frame stats.
`timescale 1ns/100ps
`include "img_consts.svh"

module img_switch_top
    import img_pkg::*;
(
    input  logic       m_img,
    input  logic       reset,
    input  logic       cke,
    input  sel_t       sel,
    output img_beat_t  m_beat,
    output frame_cnt_t frame_count,
    output logic       torn
);

    img_beat_t src_beat [`IMG_NUM_SRC];

    // each source has its own start phase and gap.
    for (genvar i = 0; i < `IMG_NUM_SRC; i++) begin : gen_src
        img_pattern_gen #(
            .SRC_ID (i)
        ) u_gen (
            .m_img  (m_img),
            .reset  (reset),
            .cke    (cke),
            .m_beat (src_beat[i])
        );
    end

    img_selector_core u_selector (
        .m_img  (m_img),
        .reset  (reset),
        .cke    (cke),
        .sel    (sel),
        .s_beat (src_beat),
        .m_beat (m_beat)
    );

    // taps the switch output.
    img_frame_stats u_stats (
        .m_img       (m_img),
        .reset       (reset),
        .cke         (cke),
        .beat        (m_beat),
        .frame_count (frame_count),
        .torn        (torn)
    );

endmodule
